// ==== vlog.f ====
source/osd_geometry_pkg.sv
source/osd_bus_pkg.sv
source/osd_raster_tracker.sv
source/osd_shared_ram.sv
source/osd_pixel_shifter.sv
source/osd_bus_regs.sv
source/osd_top.sv
test/tb_clock_gen.sv
test/osd_scoreboard.sv
test/tb_osd_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the OSD testbench with Verilator and runs it
# the run passes only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_osd_top \
  -o sim_osd > build.log 2>&1 \
  && ./obj_dir/sim_osd > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -qx "TEST PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== test/tb_osd_top.sv ====
// testbench for the OSD top level
// inputs change on the falling clock edge
// video lines are 300 active pixels plus 8 blank cycles and a frame has 80 lines
// every wait is bounded and a missing bus_ready counts as a failure

`timescale 1ns/10ps

module tb_osd_top
  import osd_geometry_pkg::*;
  import osd_bus_pkg::*;
();

  logic clk_8mhz, rst, video_de, video_hs, video_vs, bus_valid, bus_ready;
  logic [rgb_w-1:0] c64_rgb, video_rgb;
  logic [31:0] bus_addr, bus_wdata, bus_rdata, vid_lfsr, bus_lfsr;
  logic [3:0]  bus_wstrb;
  int mismatch_count, timeouts, tests_failed, mis_start, to_start;

  tb_clock_gen u_clock_gen (.clk_8mhz(clk_8mhz), .rst(rst));

  osd_top u_dut (
    .clk_8mhz(clk_8mhz), .rst(rst), .video_de(video_de), .video_hs(video_hs),
    .video_vs(video_vs), .c64_rgb(c64_rgb), .bus_valid(bus_valid), .bus_addr(bus_addr),
    .bus_wdata(bus_wdata), .bus_wstrb(bus_wstrb), .video_rgb(video_rgb),
    .bus_ready(bus_ready), .bus_rdata(bus_rdata)
  );

  osd_scoreboard u_scoreboard (
    .clk_8mhz(clk_8mhz), .rst(rst), .video_de(video_de), .video_hs(video_hs),
    .video_vs(video_vs), .c64_rgb(c64_rgb), .bus_valid(bus_valid), .bus_addr(bus_addr),
    .bus_wdata(bus_wdata), .bus_wstrb(bus_wstrb), .bus_ready(bus_ready),
    .bus_rdata(bus_rdata), .video_rgb(video_rgb), .mismatch_count(mismatch_count)
  );

  // Fibonacci LFSR with taps 32 22 2 1 and the newest bit in bit 0
  function automatic logic [31:0] lfsr_advance(input logic [31:0] s, input int n);
    logic [31:0] v;
    v = s;
    for (int i = 0; i < n; i++)
      v = {v[30:0], v[31] ^ v[21] ^ v[1] ^ v[0]};
    return v;
  endfunction

  task automatic bus_access(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    int n;
    logic done;
    @(negedge clk_8mhz);
    {bus_valid, bus_addr, bus_wdata, bus_wstrb} = {1'b1, addr, data, strb};
    n = 0;
    done = 1'b0;
    while (!done && n < 64) begin
      @(negedge clk_8mhz);
      n++;
      done = bus_ready;
    end
    bus_valid = 1'b0;
    bus_wstrb = 4'h0;
    if (!done) begin
      timeouts++;
      $display("timeout: no bus_ready within 64 cycles for address %h", addr);
    end
  endtask

  task automatic next_frame();
    int n;
    n = 0;
    @(posedge clk_8mhz);
    while (!video_vs && n < 30000) begin
      @(posedge clk_8mhz);
      n++;
    end
    if (!video_vs) begin
      timeouts++;
      $display("timeout: no vsync seen within 30000 cycles");
    end
  endtask

  task automatic finish_test(input string name);
    if (mismatch_count == mis_start && timeouts == to_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed, %0d mismatches", name, mismatch_count - mis_start);
    end
    mis_start = mismatch_count;
    to_start = timeouts;
  endtask

  // free-running video timing generator
  initial begin
    vid_lfsr = 32'he71085df;
    forever begin
      for (int line = 0; line < 80; line++) begin
        for (int p = 0; p < 308; p++) begin
          @(negedge clk_8mhz);
          vid_lfsr = lfsr_advance(vid_lfsr, 24);
          video_de = (p < 300);
          video_hs = (p == 303);
          video_vs = (line == 79 && p == 306);
          c64_rgb = (p < 300) ? vid_lfsr[23:0] : '0;
        end
      end
    end
  end

  initial begin
    int n;
    logic [31:0] waddr;
    {video_de, video_hs, video_vs, c64_rgb} = '0;
    {bus_valid, bus_addr, bus_wdata, bus_wstrb} = '0;
    {timeouts, tests_failed, mis_start, to_start} = '0;
    bus_lfsr = 32'he71085df;
    n = 0;
    while (rst && n < 20) begin
      @(posedge clk_8mhz);
      n++;
    end
    if (rst) begin
      timeouts++;
      $display("timeout: rst still high after 20 cycles");
    end

    bus_access(reg_osd_ctrl_addr, 0, 4'h0);
    bus_access(reg_offset_x_addr, 0, 4'h0);
    bus_access(reg_offset_y_addr, 0, 4'h0);
    bus_lfsr = lfsr_advance(bus_lfsr, 32);
    // enable kept off until the image is loaded
    bus_access(reg_osd_ctrl_addr, bus_lfsr & 32'hffff_fffe, 4'hf);
    bus_lfsr = lfsr_advance(bus_lfsr, 32);
    bus_access(reg_offset_x_addr, bus_lfsr, 4'hf);
    bus_lfsr = lfsr_advance(bus_lfsr, 32);
    bus_access(reg_offset_y_addr, bus_lfsr, 4'hf);
    bus_access(reg_osd_ctrl_addr, 0, 4'h0);
    bus_access(reg_offset_x_addr, 0, 4'h0);
    bus_access(reg_offset_y_addr, 0, 4'h0);
    finish_test("1 register write and read");

    for (int w = 0; w < 512; w++) begin
      bus_lfsr = lfsr_advance(bus_lfsr, 32);
      bus_access(32'h1000_0000 + w * 4, bus_lfsr, 4'hf);
    end
    bus_lfsr = lfsr_advance(bus_lfsr, 9);
    waddr = 32'h1000_0000 + {bus_lfsr[8:0], 2'b00};
    bus_access(waddr, 0, 4'h0);
    bus_access(waddr, 32'h1122_3344, 4'b0001);
    bus_access(waddr, 32'h5566_7788, 4'b0100);
    bus_access(waddr, 0, 4'h0);
    finish_test("2 RAM byte strobes");

    bus_access(reg_osd_ctrl_addr, 0, 4'hf);
    next_frame();
    next_frame();
    finish_test("3 OSD disabled");

    bus_lfsr = lfsr_advance(bus_lfsr, 6);
    bus_access(reg_offset_x_addr, bus_lfsr[5:0], 4'hf);
    bus_lfsr = lfsr_advance(bus_lfsr, 4);
    bus_access(reg_offset_y_addr, bus_lfsr[3:0] + 1, 4'hf);
    bus_access(reg_osd_ctrl_addr, 32'h1, 4'hf);
    next_frame();
    next_frame();
    finish_test("4 tall window");

    bus_access(reg_osd_ctrl_addr, 32'h3, 4'hf);
    next_frame();
    next_frame();
    finish_test("5 short window");

    bus_access(reg_osd_ctrl_addr, 32'h1, 4'hf);
    next_frame();
    // reads span the frame, idle cycles move them against the fetch strobes
    for (int i = 0; i < 10000; i++) begin
      bus_lfsr = lfsr_advance(bus_lfsr, 10);
      if (bus_lfsr[9])
        @(negedge clk_8mhz);
      bus_access(32'h1000_0000 + {bus_lfsr[8:0], 2'b00}, 0, 4'h0);
    end
    finish_test("6 bus reads during scan-out");

    $display("tests failed %0d of 6, mismatches %0d, timeouts %0d",
             tests_failed, mismatch_count, timeouts);
    if (tests_failed == 0 && mismatch_count == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== test/osd_scoreboard.sv ====
// watches the OSD top level and compares video_rgb and bus reads with a model
// the model steps 1 ns after each rising edge, when DUT inputs and outputs are stable
// nothing is compared while rst is high

`timescale 1ns/10ps

module osd_scoreboard
  import osd_geometry_pkg::*;
  import osd_bus_pkg::*;
(
  input  logic                  clk_8mhz,
  input  logic                  rst,
  input  logic                  video_de,
  input  logic                  video_hs,
  input  logic                  video_vs,
  input  logic [rgb_w-1:0]      c64_rgb,
  input  logic                  bus_valid,
  input  logic [bus_addr_w-1:0] bus_addr,
  input  logic [bus_data_w-1:0] bus_wdata,
  input  logic [bus_strb_w-1:0] bus_wstrb,
  input  logic                  bus_ready,
  input  logic [bus_data_w-1:0] bus_rdata,
  input  logic [rgb_w-1:0]      video_rgb,
  output int                    mismatch_count
);

  logic [7:0] mem [0:2047];
  logic [8:0] m_vx, m_vy, m_ox, m_oy;
  logic       m_en, m_short, m_fetch_d, prev_ready;
  logic [7:0] m_offx, m_offy, m_shift;
  logic [1:0] m_lane;
  logic [31:0] m_rdata;

  // expected pixel colour from the window state and the incoming video
  function automatic logic [rgb_w-1:0] expected_rgb(input logic de, input logic active,
                                                   input logic pix, input logic [rgb_w-1:0] c64);
    if (!de)
      return '0;
    if (!active)
      return c64;
    return pix ? osd_fg_rgb : osd_bg_rgb;
  endfunction

  function automatic logic window_open(input logic de);
    logic [8:0] hgt;
    hgt = m_short ? 9'(osd_short_lines) : 9'(osd_tall_lines);
    return m_en && de && (m_ox < 9'(osd_width)) && (m_oy < hgt);
  endfunction

  initial mismatch_count = 0;

  always @(posedge clk_8mhz) begin
    logic       act, fch, first, mx, my, exp_ready;
    logic [10:0] oaddr;
    logic [8:0]  waddr;
    logic [31:0] exp_rd;
    logic [3:0]  nib;
    #1;
    act = window_open(video_de);
    fch = act && (m_ox[2:0] == 3'd0);
    oaddr = {m_oy[5:0], m_ox[7:3]};
    nib = bus_addr[31:28];
    first = bus_valid && !prev_ready;
    waddr = fch ? oaddr[10:2] : bus_addr[10:2];
    // ready pulse due after this edge
    exp_ready = first && (nib == reg_region_nibble || (nib == ram_region_nibble && !fch));

    ////////////////////
    // shifter and RAM
    ////////////////////
    if (rst)
      m_shift = 8'd0;
    else if (m_fetch_d)
      m_shift = m_rdata[m_lane*8 +: 8];
    else
      m_shift = {m_shift[6:0], 1'b0};
    m_rdata = {mem[{waddr, 2'd3}], mem[{waddr, 2'd2}], mem[{waddr, 2'd1}], mem[{waddr, 2'd0}]};
    if (first && nib == ram_region_nibble && !fch && !rst) begin
      for (int i = 0; i < 4; i++)
        if (bus_wstrb[i])
          mem[{waddr, 2'(i)}] = bus_wdata[i*8 +: 8];
    end

    ////////////////////
    // registers and counters
    ////////////////////
    mx = (m_vx == {1'b0, m_offx});
    my = (m_vy == {1'b0, m_offy});
    if (rst) begin
      {m_vx, m_vy, m_ox, m_oy} = '0;
      m_en = 1'b0;
      m_short = 1'b0;
      m_offx = 8'd1;
      m_offy = 8'd1;
      m_fetch_d = 1'b0;
      m_lane = 2'd0;
    end else begin
      m_fetch_d = fch;
      m_lane = oaddr[1:0];
      if (first && nib == reg_region_nibble && bus_wstrb == 4'hf) begin
        if (bus_addr == reg_osd_ctrl_addr)
          {m_short, m_en} = bus_wdata[1:0];
        else if (bus_addr == reg_offset_x_addr)
          m_offx = bus_wdata[7:0];
        else if (bus_addr == reg_offset_y_addr)
          m_offy = bus_wdata[7:0];
      end
      if (video_vs) begin
        m_vy = '0;
      end else if (video_hs) begin
        if (m_vx != '0)
          m_vy = m_vy + 1'b1;
        m_vx = '0;
      end else if (video_de) begin
        m_vx = m_vx + 1'b1;
      end
      if (mx && my) begin
        m_ox = '0;
        m_oy = '0;
      end else if (mx) begin
        m_ox = '0;
        m_oy = m_oy + 1'b1;
      end else begin
        m_ox = m_ox + 1'b1;
      end
    end
    prev_ready = bus_ready;

    ////////////////////
    // comparison
    ////////////////////
    if (!rst) begin
      if (video_rgb !== expected_rgb(video_de, window_open(video_de), m_shift[7], c64_rgb)) begin
        mismatch_count++;
        $display("MISMATCH video_rgb expected %h got %h",
                 expected_rgb(video_de, window_open(video_de), m_shift[7], c64_rgb), video_rgb);
      end
      if (bus_ready !== exp_ready) begin
        mismatch_count++;
        $display("MISMATCH bus_ready at %h expected %h got %h", bus_addr, exp_ready, bus_ready);
      end
      if (bus_ready && bus_valid && bus_wstrb == 4'h0) begin
        exp_rd = '0;
        if (nib == ram_region_nibble)
          exp_rd = m_rdata;
        else if (bus_addr == reg_osd_ctrl_addr)
          exp_rd = {30'd0, m_short, m_en};
        else if (bus_addr == reg_offset_x_addr)
          exp_rd = {24'd0, m_offx};
        else if (bus_addr == reg_offset_y_addr)
          exp_rd = {24'd0, m_offy};
        if (bus_rdata !== exp_rd) begin
          mismatch_count++;
          $display("MISMATCH bus_rdata at %h expected %h got %h", bus_addr, exp_rd, bus_rdata);
        end
      end
    end
  end

endmodule

// ==== test/tb_clock_gen.sv ====
// clock and reset for the OSD testbench
// 10 ns period, rst held high for the first 3 rising edges

`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_8mhz,
  output logic rst
);

  initial begin
    clk_8mhz = 1'b0;
    forever #5 clk_8mhz = ~clk_8mhz;
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk_8mhz);
    @(negedge clk_8mhz);
    rst = 1'b0;
  end

endmodule

// ==== source/osd_top.sv ====
// OSD path top level, everything on clk_8mhz
// video timing and colour come in from outside, the CPU bus writes the image
// OSD fetches stall RAM accesses on the bus, video is never held off

`timescale 1ns/10ps

module osd_top
  import osd_geometry_pkg::*;
  import osd_bus_pkg::*;
(
  input  logic                  clk_8mhz,
  input  logic                  rst,
  input  logic                  video_de,
  input  logic                  video_hs,
  input  logic                  video_vs,
  input  logic [rgb_w-1:0]      c64_rgb,
  input  logic                  bus_valid,
  input  logic [bus_addr_w-1:0] bus_addr,
  input  logic [bus_data_w-1:0] bus_wdata,
  input  logic [bus_strb_w-1:0] bus_wstrb,
  output logic [rgb_w-1:0]      video_rgb,
  output logic                  bus_ready,
  output logic [bus_data_w-1:0] bus_rdata
);

  logic                  osd_enable;
  logic                  osd_short;
  logic [offset_w-1:0]   offset_x;
  logic [offset_w-1:0]   offset_y;
  logic                  cpu_ram_sel;
  logic [bus_data_w-1:0] ram_rdata;
  logic                  osd_active;
  logic                  osd_fetch;
  logic [osd_addr_w-1:0] osd_addr;

  osd_bus_regs u_bus_regs (
    .clk_8mhz    (clk_8mhz),
    .rst         (rst),
    .bus_valid   (bus_valid),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .bus_wstrb   (bus_wstrb),
    .stall       (osd_fetch),
    .ram_rdata   (ram_rdata),
    .bus_ready   (bus_ready),
    .bus_rdata   (bus_rdata),
    .cpu_ram_sel (cpu_ram_sel),
    .osd_enable  (osd_enable),
    .osd_short   (osd_short),
    .offset_x    (offset_x),
    .offset_y    (offset_y)
  );

  osd_raster_tracker u_tracker (
    .clk_8mhz   (clk_8mhz),
    .rst        (rst),
    .video_de   (video_de),
    .video_hs   (video_hs),
    .video_vs   (video_vs),
    .osd_enable (osd_enable),
    .osd_short  (osd_short),
    .offset_x   (offset_x),
    .offset_y   (offset_y),
    .osd_active (osd_active),
    .osd_fetch  (osd_fetch),
    .osd_addr   (osd_addr)
  );

  osd_shared_ram u_shared_ram (
    .clk_8mhz    (clk_8mhz),
    .rst         (rst),
    .osd_fetch   (osd_fetch),
    .osd_addr    (osd_addr),
    .cpu_ram_sel (cpu_ram_sel),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .bus_wstrb   (bus_wstrb),
    .ram_rdata   (ram_rdata)
  );

  osd_pixel_shifter u_pixel_shifter (
    .clk_8mhz   (clk_8mhz),
    .rst        (rst),
    .osd_fetch  (osd_fetch),
    .osd_addr   (osd_addr[1:0]),
    .osd_active (osd_active),
    .video_de   (video_de),
    .ram_rdata  (ram_rdata),
    .c64_rgb    (c64_rgb),
    .video_rgb  (video_rgb)
  );

endmodule

// ==== source/osd_bus_regs.sv ====
// CPU bus front end with the OSD control registers
// bus_ready is a one-cycle pulse, RAM accesses wait out OSD fetches
// registers take only full-word writes, a zero strobe is a read

`timescale 1ns/10ps

module osd_bus_regs
  import osd_geometry_pkg::*;
  import osd_bus_pkg::*;
(
  input  logic                  clk_8mhz,
  input  logic                  rst,
  input  logic                  bus_valid,
  input  logic [bus_addr_w-1:0] bus_addr,
  input  logic [bus_data_w-1:0] bus_wdata,
  input  logic [bus_strb_w-1:0] bus_wstrb,
  input  logic                  stall,
  input  logic [bus_data_w-1:0] ram_rdata,
  output logic                  bus_ready,
  output logic [bus_data_w-1:0] bus_rdata,
  output logic                  cpu_ram_sel,
  output logic                  osd_enable,
  output logic                  osd_short,
  output logic [offset_w-1:0]   offset_x,
  output logic [offset_w-1:0]   offset_y
);

  bus_region_e region;
  logic        reg_wr;

  always_comb begin
    case (bus_addr[bus_addr_w-1 -: 4])
      ram_region_nibble: region = region_ram;
      reg_region_nibble: region = region_regs;
      default:           region = region_none;
    endcase
  end

  // single write per access, not repeated in the ready cycle
  assign cpu_ram_sel = bus_valid && !bus_ready && (region == region_ram);
  assign reg_wr = bus_valid && !bus_ready && (region == region_regs) && (bus_wstrb == '1);

  ////////////////////
  // control registers
  ////////////////////

  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      osd_enable <= 1'b0;
      osd_short  <= 1'b0;
      offset_x   <= offset_w'(1);
      offset_y   <= offset_w'(1);
    end else if (reg_wr) begin
      case (bus_addr)
        reg_osd_ctrl_addr: begin
          osd_enable <= bus_wdata[0];
          osd_short  <= bus_wdata[1];
        end
        reg_offset_x_addr: offset_x <= bus_wdata[offset_w-1:0];
        reg_offset_y_addr: offset_y <= bus_wdata[offset_w-1:0];
        default: ;
      endcase
    end
  end

  // read data mux
  always_comb begin
    bus_rdata = '0;
    case (region)
      region_ram: bus_rdata = ram_rdata;
      region_regs: begin
        case (bus_addr)
          reg_osd_ctrl_addr: bus_rdata = bus_data_w'({osd_short, osd_enable});
          reg_offset_x_addr: bus_rdata = bus_data_w'(offset_x);
          reg_offset_y_addr: bus_rdata = bus_data_w'(offset_y);
          default:           bus_rdata = '0;
        endcase
      end
      default: bus_rdata = '0;
    endcase
  end

  ////////////////////
  // ready generation
  ////////////////////

  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      bus_ready <= 1'b0;
    end else begin
      case (region)
        region_ram:  bus_ready <= ~bus_ready & bus_valid & ~stall;
        region_regs: bus_ready <= ~bus_ready & bus_valid;
        default:     bus_ready <= 1'b0;
      endcase
    end
  end

endmodule

// ==== source/osd_pixel_shifter.sv ====
// turns fetched OSD bytes into pixels and mixes them over the video colour
// a byte lands in the shift register two cycles after its fetch strobe
// msb of each byte is the leftmost pixel

`timescale 1ns/10ps

module osd_pixel_shifter
  import osd_geometry_pkg::*;
  import osd_bus_pkg::*;
(
  input  logic                  clk_8mhz,
  input  logic                  rst,
  input  logic                  osd_fetch,
  input  logic [1:0]            osd_addr,
  input  logic                  osd_active,
  input  logic                  video_de,
  input  logic [bus_data_w-1:0] ram_rdata,
  input  logic [rgb_w-1:0]      c64_rgb,
  output logic [rgb_w-1:0]      video_rgb
);

  logic       fetch_d;
  logic [1:0] lane_d;
  logic [7:0] fetched_byte;
  logic [7:0] pix_shift;
  logic [rgb_w-1:0] osd_rgb;

  // line up strobe and lane with the RAM read data
  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      fetch_d <= 1'b0;
      lane_d  <= 2'd0;
    end else begin
      fetch_d <= osd_fetch;
      lane_d  <= osd_addr;
    end
  end

  assign fetched_byte = ram_rdata[lane_d*8 +: 8];

  always_ff @(posedge clk_8mhz) begin
    if (rst)
      pix_shift <= 8'd0;
    else if (fetch_d)
      pix_shift <= fetched_byte;
    else
      pix_shift <= {pix_shift[6:0], 1'b0};
  end

  assign osd_rgb   = pix_shift[7] ? osd_fg_rgb : osd_bg_rgb;
  // blank outside active video
  assign video_rgb = video_de ? (osd_active ? osd_rgb : c64_rgb) : '0;

endmodule

// ==== source/osd_shared_ram.sv ====
// 2 KB image RAM shared by the CPU bus and the OSD fetch path
// an OSD fetch takes the address and blocks any CPU write in that cycle
// read data appears one cycle after the address, contents are not cleared

`timescale 1ns/10ps

module osd_shared_ram
  import osd_geometry_pkg::*;
  import osd_bus_pkg::*;
(
  input  logic                  clk_8mhz,
  input  logic                  rst,
  input  logic                  osd_fetch,
  input  logic [osd_addr_w-1:0] osd_addr,
  input  logic                  cpu_ram_sel,
  input  logic [bus_addr_w-1:0] bus_addr,
  input  logic [bus_data_w-1:0] bus_wdata,
  input  logic [bus_strb_w-1:0] bus_wstrb,
  output logic [bus_data_w-1:0] ram_rdata
);

  localparam int lane_w = bus_data_w / bus_strb_w;
  localparam int ram_depth = 1 << ram_word_addr_w;

  logic [ram_word_addr_w-1:0] word_addr;
  logic [bus_strb_w-1:0]      lane_we;

  ////////////////////
  // port arbitration
  ////////////////////

  // OSD side always wins
  assign word_addr = osd_fetch ? osd_addr[osd_addr_w-1:2]
                               : bus_addr[ram_word_addr_w+1:2];

  // no writes while the core is held in reset
  assign lane_we = (cpu_ram_sel && !osd_fetch && !rst) ? bus_wstrb : '0;

  ////////////////////
  // byte lanes
  ////////////////////

  for (genvar gi = 0; gi < bus_strb_w; gi++) begin : g_lane
    logic [lane_w-1:0] mem [0:ram_depth-1];

    always_ff @(posedge clk_8mhz) begin
      if (lane_we[gi])
        mem[word_addr] <= bus_wdata[gi*lane_w +: lane_w];
      // read returns the old byte on a same-cycle write
      ram_rdata[gi*lane_w +: lane_w] <= mem[word_addr];
    end
  end

endmodule

// ==== source/osd_raster_tracker.sv ====
// follows incoming video timing and locates the OSD window on it
// the window origin is where the raster position equals both offsets
// osd_fetch fires on the first pixel of every byte inside the window

`timescale 1ns/10ps

module osd_raster_tracker
  import osd_geometry_pkg::*;
(
  input  logic                  clk_8mhz,
  input  logic                  rst,
  input  logic                  video_de,
  input  logic                  video_hs,
  input  logic                  video_vs,
  input  logic                  osd_enable,
  input  logic                  osd_short,
  input  logic [offset_w-1:0]   offset_x,
  input  logic [offset_w-1:0]   offset_y,
  output logic                  osd_active,
  output logic                  osd_fetch,
  output logic [osd_addr_w-1:0] osd_addr
);

  logic [video_pos_w-1:0] video_pos_x;
  logic [video_pos_w-1:0] video_pos_y;
  logic [video_pos_w-1:0] osd_x;
  logic [video_pos_w-1:0] osd_y;
  logic [video_pos_w-1:0] win_height;
  logic                   match_x;
  logic                   match_y;

  assign match_x = (video_pos_x == video_pos_w'(offset_x));
  assign match_y = (video_pos_y == video_pos_w'(offset_y));

  // raster position, y only steps on lines that carried pixels
  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      video_pos_x <= '0;
      video_pos_y <= '0;
    end else if (video_vs) begin
      video_pos_y <= '0;
    end else if (video_hs) begin
      video_pos_x <= '0;
      if (video_pos_x != '0)
        video_pos_y <= video_pos_y + 1'b1;
    end else if (video_de) begin
      video_pos_x <= video_pos_x + 1'b1;
    end
  end

  // window-relative position
  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      osd_x <= '0;
      osd_y <= '0;
    end else if (match_x && match_y) begin
      osd_x <= '0;
      osd_y <= '0;
    end else if (match_x) begin
      osd_x <= '0;
      osd_y <= osd_y + 1'b1;
    end else begin
      osd_x <= osd_x + 1'b1;
    end
  end

  assign win_height = osd_short ? video_pos_w'(osd_short_lines) : video_pos_w'(osd_tall_lines);

  assign osd_active = osd_enable && video_de && (osd_x < video_pos_w'(osd_width))
                      && (osd_y < win_height);
  assign osd_fetch  = osd_active && (osd_x[2:0] == 3'd0);
  // 32 bytes per window line
  assign osd_addr   = {osd_y[5:0], osd_x[7:3]};

endmodule

// ==== source/osd_bus_pkg.sv ====
// CPU bus widths and address map
// the top address nibble picks the region, registers sit at fixed word addresses
// unmapped regions are never acknowledged, so a master must not access them

package osd_bus_pkg;

  ////////////////////
  // bus widths
  ////////////////////

  localparam int bus_addr_w = 32;
  localparam int bus_data_w = 32;
  localparam int bus_strb_w = 4;

  ////////////////////
  // address map
  ////////////////////

  localparam logic [3:0] ram_region_nibble = 4'h1;
  localparam logic [3:0] reg_region_nibble = 4'h3;

  // bit 0 enable, bit 1 short window
  localparam logic [bus_addr_w-1:0] reg_osd_ctrl_addr = 32'h3000_0000;
  localparam logic [bus_addr_w-1:0] reg_offset_x_addr = 32'h3000_0010;
  localparam logic [bus_addr_w-1:0] reg_offset_y_addr = 32'h3000_0014;

  // region picked by the top nibble
  typedef enum logic [1:0] {
    region_ram,
    region_regs,
    region_none
  } bus_region_e;

endpackage

// ==== source/osd_geometry_pkg.sv ====
// geometry of the OSD window, its backing RAM and the video path
// window is 256 pixels wide at 1 bit per pixel, so one byte holds eight pixels
// raster counters are 9 bits, so lines longer than 511 pixels wrap

package osd_geometry_pkg;

  ////////////////////
  // raster and window
  ////////////////////

  localparam int video_pos_w = 9;
  localparam int osd_width = 256;
  localparam int osd_tall_lines = 64;
  localparam int osd_short_lines = 8;
  localparam int offset_w = 8;

  ////////////////////
  // OSD image RAM
  ////////////////////

  // 2 KB image as 512 words of 32 bits
  localparam int osd_addr_w = 11;
  localparam int ram_word_addr_w = 9;

  ////////////////////
  // colours
  ////////////////////

  localparam int rgb_w = 24;
  localparam logic [rgb_w-1:0] osd_fg_rgb = 24'hff_ff_ff;
  // dark blue-grey behind the text
  localparam logic [rgb_w-1:0] osd_bg_rgb = 24'h30_40_50;

endpackage
